//--- Makefile
# Verilator build and run for the forwarding-data generator

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= forward_data_generator_tb
RTL_TOP   ?= forward_data_generator
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Pass or fail is taken from the log, not from the simulator exit code
run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/forward_control.sv
// Control sequencer of the forwarding-data generator
//   Start, configuration request, run and pause FSM
//   Hop-count configuration register
//   Busy and forward-enable levels
`timescale 1ns/100ps

module forward_control
    import forward_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              start,
    input  logic              config_ready,
    input  fwd_config_t       config_in,
    input  logic              output_prog_full,
    output logic              config_request,
    output logic              busy,
    output logic              forward_enable,
    output logic [HOPS_W-1:0] fwd_hops
);

    fwd_state_e current_state;
    fwd_state_e next_state;

    // ------------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator)
            current_state <= RESET;
        else
            current_state <= next_state;
    end

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = current_state;
        case (current_state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (start)
                    next_state = SETUP_WAIT;
            end
            SETUP_WAIT: begin
                if (config_ready)
                    next_state = SETUP;
            end
            SETUP: begin
                if (config_in.valid)
                    next_state = START;
            end
            START: begin
                next_state = BUSY;
            end
            BUSY: begin
                // Output queue near full
                if (output_prog_full)
                    next_state = PAUSE;
            end
            PAUSE: begin
                if (!output_prog_full)
                    next_state = BUSY;
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Configuration request and hop count
    // ------------------------------------------------------------------------
    // One-cycle request on entry into SETUP
    always_ff @(posedge ap_clk) begin
        if (areset_generator)
            config_request <= 1'b0;
        else
            config_request <= (current_state == SETUP_WAIT) && config_ready;
    end

    // All ones until configured
    always_ff @(posedge ap_clk) begin
        if (areset_generator)
            fwd_hops <= '1;
        else if (current_state == SETUP && config_in.valid)
            fwd_hops <= config_in.hops;
    end

    // ------------------------------------------------------------------------
    // Status levels
    // ------------------------------------------------------------------------
    always_comb begin
        busy           = 1'b0;
        forward_enable = 1'b0;
        case (current_state)
            START: begin
                busy = 1'b1;
            end
            BUSY: begin
                busy           = 1'b1;
                forward_enable = 1'b1;
            end
            PAUSE: begin
                busy = 1'b1;
            end
            default: begin
                busy           = 1'b0;
                forward_enable = 1'b0;
            end
        endcase
    end

endmodule : forward_control

//--- hdl/forward_data_generator.sv
// Forwarding-data generator for a graph-processing engine lane
//   Input side with response register and input queue
//   Control sequencer and hop stage
//   Output queue drained by the consumer
`timescale 1ns/100ps

module forward_data_generator
    import forward_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  logic         start,
    input  logic         config_ready,
    input  fwd_config_t  config_in,
    input  packet_beat_t response_in,
    input  logic         request_pop,
    output logic         config_request,
    output logic         busy,
    output logic         response_prog_full,
    output packet_beat_t request_out
);

    packet_beat_t      queued_packet;
    packet_beat_t      forward_packet;
    logic              forward_enable;
    logic [HOPS_W-1:0] fwd_hops;
    logic              output_prog_full;

    // ------------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------------
    response_intake #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) response_intake_i (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .response_in       (response_in),
        .forward_enable    (forward_enable),
        .queued_packet     (queued_packet),
        .response_prog_full(response_prog_full)
    );

    // ------------------------------------------------------------------------
    // Control and hop stage
    // ------------------------------------------------------------------------
    forward_control forward_control_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .config_ready    (config_ready),
        .config_in       (config_in),
        .output_prog_full(output_prog_full),
        .config_request  (config_request),
        .busy            (busy),
        .forward_enable  (forward_enable),
        .fwd_hops        (fwd_hops)
    );

    hop_forwarder hop_forwarder_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .queued_packet   (queued_packet),
        .fwd_hops        (fwd_hops),
        .forward_packet  (forward_packet)
    );

    // Output queue drained by the consumer
    packet_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) output_queue_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr              (forward_packet),
        .pop             (request_pop),
        .rd              (request_out),
        .empty           (),
        .prog_full       (output_prog_full)
    );

endmodule : forward_data_generator

//--- hdl/forward_pkg.sv
// Shared definitions for the forwarding-data generator
//   Field widths for packet route, hops, address and data
//   Packet subclass and control state enums
//   Packet, packet beat and configuration structs
package forward_pkg;

    // ------------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------------
    parameter int NODE_W = 4;
    parameter int HOPS_W = 8;
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // ------------------------------------------------------------------------
    // Enumerations
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        SUBCLASS_VERTEX  = 2'd0,
        SUBCLASS_EDGE    = 2'd1,
        SUBCLASS_CONTROL = 2'd2,
        SUBCLASS_DATA    = 2'd3
    } packet_subclass_e;

    // Control sequencer states
    typedef enum logic [2:0] {
        RESET      = 3'd0,
        IDLE       = 3'd1,
        SETUP_WAIT = 3'd2,
        SETUP      = 3'd3,
        START      = 3'd4,
        BUSY       = 3'd5,
        PAUSE      = 3'd6
    } fwd_state_e;

    // ------------------------------------------------------------------------
    // Packet and configuration types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [NODE_W-1:0] route_from;
        logic [NODE_W-1:0] route_to;
        logic [HOPS_W-1:0] hops;
        logic [ADDR_W-1:0] address;
        packet_subclass_e  subclass;
    } packet_meta_t;

    typedef struct packed {
        packet_meta_t      meta;
        logic [DATA_W-1:0] data;
    } packet_t;

    // One transfer on a packet link
    typedef struct packed {
        logic    valid;
        packet_t payload;
    } packet_beat_t;

    typedef struct packed {
        logic              valid;
        logic [HOPS_W-1:0] hops;
    } fwd_config_t;

endpackage : forward_pkg

//--- hdl/hop_forwarder.sv
// Hop stage of the forwarding-data generator
//   Saturating hop-count subtraction
//   Zero-hop packet filter
//   Registered forward stage, one cycle of latency
`timescale 1ns/100ps

module hop_forwarder
    import forward_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  packet_beat_t      queued_packet,
    input  logic [HOPS_W-1:0] fwd_hops,
    output packet_beat_t      forward_packet
);

    logic [HOPS_W-1:0] hops_in;
    logic [HOPS_W-1:0] hops_left;
    logic              hops_live;
    logic              fwd_valid;
    packet_t           fwd_payload;

    assign hops_in   = queued_packet.payload.meta.hops;
    assign hops_live = |hops_in;

    // Saturate at zero
    assign hops_left = (hops_in > fwd_hops) ? (hops_in - fwd_hops) : '0;

    // ------------------------------------------------------------------------
    // Forward stage
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator)
            fwd_valid <= 1'b0;
        else
            fwd_valid <= queued_packet.valid & hops_live;
    end

    // Only the hop field changes on the way through
    always_ff @(posedge ap_clk) begin
        if (queued_packet.valid) begin
            fwd_payload.meta.route_from <= queued_packet.payload.meta.route_from;
            fwd_payload.meta.route_to   <= queued_packet.payload.meta.route_to;
            fwd_payload.meta.hops       <= hops_left;
            fwd_payload.meta.address    <= queued_packet.payload.meta.address;
            fwd_payload.meta.subclass   <= queued_packet.payload.meta.subclass;
            fwd_payload.data            <= queued_packet.payload.data;
        end
    end

    assign forward_packet = '{valid: fwd_valid, payload: fwd_payload};

endmodule : hop_forwarder

//--- hdl/packet_fifo.sv
// Synchronous packet FIFO
//   Circular buffer with read and write pointers and an occupancy count
//   Registered read data, valid for one cycle per accepted pop
//   Registered programmable-full flag
`timescale 1ns/100ps

module packet_fifo
    import forward_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  packet_beat_t wr,
    input  logic         pop,
    output packet_beat_t rd,
    output logic         empty,
    output logic         prog_full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    packet_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               wr_en;
    logic               rd_en;
    logic               rd_valid;
    packet_t            rd_payload;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Writes into a full buffer are dropped
    assign wr_en = wr.valid & ~full;
    assign rd_en = pop & ~empty;

    // ------------------------------------------------------------------------
    // Pointers, count and flags
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            rd_valid  <= 1'b0;
            prog_full <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            rd_valid  <= rd_en;
            // Lags the count by one cycle
            prog_full <= (count >= CNT_W'(PROG_THRESH));
        end
    end

    // ------------------------------------------------------------------------
    // Storage and read data
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en)
            mem[wr_ptr] <= wr.payload;
        if (rd_en)
            rd_payload <= mem[rd_ptr];
    end

    assign rd = '{valid: rd_valid, payload: rd_payload};

endmodule : packet_fifo

//--- hdl/response_intake.sv
// Input side of the forwarding-data generator
//   Input register for engine response beats
//   Input queue, popped while forwarding is enabled
`timescale 1ns/100ps

module response_intake
    import forward_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  packet_beat_t response_in,
    input  logic         forward_enable,
    output packet_beat_t queued_packet,
    output logic         response_prog_full
);

    logic         in_valid;
    packet_t      in_payload;
    packet_beat_t in_beat;
    logic         queue_empty;
    logic         queue_pop;

    // Register the incoming beat
    always_ff @(posedge ap_clk) begin
        if (areset_generator)
            in_valid <= 1'b0;
        else
            in_valid <= response_in.valid;
    end

    always_ff @(posedge ap_clk) begin
        in_payload <= response_in.payload;
    end

    assign in_beat = '{valid: in_valid, payload: in_payload};

    // Packets wait here until the sequencer is running
    assign queue_pop = forward_enable & ~queue_empty;

    packet_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) input_queue_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr              (in_beat),
        .pop             (queue_pop),
        .rd              (queued_packet),
        .empty           (queue_empty),
        .prog_full       (response_prog_full)
    );

endmodule : response_intake

//--- verif/forward_data_generator_tb.sv
// Testbench for the forwarding-data generator
//   Clock, reset and falling-edge stimulus
//   Reference hop rule and expectation queue
//   Output compare process, watchdog and closing report
`timescale 1ns/100ps

module forward_data_generator_tb
    import forward_pkg::*;
;

    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;
    localparam int N_PRE       = 6;
    localparam int N_RAND      = 60;
    localparam int N_FILL_MAX  = 48;
    localparam int CYCLES_PER_PACKET = 16;
    localparam int WATCHDOG_CYCLES = 8 + (N_PRE + N_RAND + N_FILL_MAX) * CYCLES_PER_PACKET
                                   + 16 * FIFO_DEPTH;

    localparam int POP_OFF    = 0;
    localparam int POP_ON     = 1;
    localparam int POP_RANDOM = 2;

    logic              ap_clk;
    logic              areset_generator;
    logic              start;
    logic              config_ready;
    fwd_config_t       config_in;
    packet_beat_t      response_in;
    logic              request_pop;
    logic              config_request;
    logic              busy;
    logic              response_prog_full;
    packet_beat_t      request_out;

    integer            seed;
    int                errors;
    int                checks;
    int                out_count;
    int                nonzero_sent;
    int                req_cycles;
    int                pop_mode;
    bit                busy_seen;
    string             test_name;
    logic [HOPS_W-1:0] cfg_hops;
    logic [HOPS_W-1:0] pre_hops [N_PRE];
    packet_t           expected_q [$];
    packet_t           exp_pkt;

    forward_data_generator #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) forward_data_generator_i (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .start             (start),
        .config_ready      (config_ready),
        .config_in         (config_in),
        .response_in       (response_in),
        .request_pop       (request_pop),
        .config_request    (config_request),
        .busy              (busy),
        .response_prog_full(response_prog_full),
        .request_out       (request_out)
    );

    initial ap_clk = 1'b0;
    always #50 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------
    // Zero-hop packets are dropped and the rest lose the configured count down to zero
    function automatic bit expected_packet(input packet_t pkt, input logic [HOPS_W-1:0] cfg,
                                           output packet_t exp_out);
        int remaining;
        exp_out = pkt;
        if (pkt.meta.hops == '0)
            return 1'b0;
        remaining = int'(pkt.meta.hops) - int'(cfg);
        if (remaining < 0)
            remaining = 0;
        exp_out.meta.hops = HOPS_W'(remaining);
        return 1'b1;
    endfunction

    function automatic packet_t random_packet(input logic [HOPS_W-1:0] hops);
        packet_t     pkt;
        logic [31:0] r;
        r = $random(seed);
        pkt.meta.route_from = r[3:0];
        pkt.meta.route_to   = r[7:4];
        pkt.meta.subclass   = packet_subclass_e'(r[9:8]);
        pkt.meta.hops       = hops;
        pkt.meta.address    = $random(seed);
        pkt.data            = $random(seed);
        return pkt;
    endfunction

    task automatic check_value(input string label, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH [%s] %s expected %h actual %h", test_name, label,
                     expected, actual);
        end
    endtask

    // Step to the next falling edge and update the consumer pop level
    task automatic next_cycle();
        @(negedge ap_clk);
        case (pop_mode)
            POP_ON:     request_pop = 1'b1;
            POP_RANDOM: request_pop = 1'($random(seed) & 1);
            default:    request_pop = 1'b0;
        endcase
    endtask

    task automatic send_packet(input packet_t pkt);
        packet_t exp_out;
        response_in = '{valid: 1'b1, payload: pkt};
        if (expected_packet(pkt, cfg_hops, exp_out)) begin
            expected_q.push_back(exp_out);
            nonzero_sent++;
        end
        next_cycle();
        response_in = '0;
    endtask

    task automatic wait_input_room();
        while (response_prog_full)
            next_cycle();
    endtask

    task automatic drain_output();
        while (expected_q.size() != 0)
            next_cycle();
        // Extra cycles to catch stray outputs
        repeat (10) next_cycle();
        check_value("output count", 128'(nonzero_sent), 128'(out_count));
    endtask

    task automatic end_simulation();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    // ------------------------------------------------------------------------
    // Compare process and monitors
    // ------------------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (busy)
            busy_seen = 1'b1;
        if (config_request)
            req_cycles++;
        if (request_out.valid === 1'b1) begin
            out_count++;
            if (!busy_seen) begin
                errors++;
                $display("ERROR [%s] output packet appeared before busy rose", test_name);
            end
            if (expected_q.size() == 0) begin
                errors++;
                $display("ERROR [%s] output packet appeared with none expected", test_name);
            end else begin
                exp_pkt = expected_q.pop_front();
                check_value("request_out payload", 128'(exp_pkt), 128'(request_out.payload));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        errors++;
        $display("ERROR [%s] watchdog timeout after %0d cycles", test_name, WATCHDOG_CYCLES);
        end_simulation();
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        int n;
        int gap;
        logic [31:0] r;
        seed = 88387;
        errors = 0;
        checks = 0;
        out_count = 0;
        nonzero_sent = 0;
        req_cycles = 0;
        busy_seen = 1'b0;
        pop_mode = POP_OFF;
        test_name = "reset";
        cfg_hops = 8'd3;
        pre_hops[0] = 8'd5;
        pre_hops[1] = 8'd0;
        pre_hops[2] = 8'd3;
        pre_hops[3] = 8'd1;
        pre_hops[4] = 8'd200;
        pre_hops[5] = 8'd0;
        areset_generator = 1'b1;
        start = 1'b0;
        config_ready = 1'b0;
        config_in = '0;
        response_in = '0;
        request_pop = 1'b0;

        repeat (8) @(negedge ap_clk);
        areset_generator = 1'b0;
        next_cycle();
        check_value("request_out valid", 128'(0), 128'(request_out.valid));
        check_value("config_request", 128'(0), 128'(config_request));
        check_value("busy", 128'(0), 128'(busy));
        check_value("response_prog_full", 128'(0), 128'(response_prog_full));
        config_ready = 1'b1;
        repeat (6) next_cycle();
        check_value("config_request cycles before start", 128'(0), 128'(req_cycles));

        // Packets queued before configuration
        test_name = "pre_config";
        pop_mode = POP_ON;
        for (n = 0; n < N_PRE; n++)
            send_packet(random_packet(pre_hops[n]));
        repeat (10) next_cycle();
        check_value("outputs before start", 128'(0), 128'(out_count));

        test_name = "configure";
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        while (!config_request)
            next_cycle();
        check_value("busy before config", 128'(0), 128'(busy));
        config_in = '{valid: 1'b1, hops: cfg_hops};
        next_cycle();
        config_in = '0;
        check_value("config_request one cycle", 128'(0), 128'(config_request));
        while (!busy)
            next_cycle();

        test_name = "pre_config_drain";
        drain_output();

        // Random packets against a random consumer
        test_name = "random";
        pop_mode = POP_RANDOM;
        for (n = 0; n < N_RAND; n++) begin
            wait_input_room();
            r = $random(seed);
            send_packet(random_packet(r[8] ? r[7:0] : (r[7:0] & 8'h07)));
            gap = $random(seed) & 3;
            repeat (gap) next_cycle();
        end
        pop_mode = POP_ON;
        drain_output();

        // Consumer stalled until the input queue reports near full
        test_name = "backpressure";
        pop_mode = POP_OFF;
        next_cycle();
        n = 0;
        while (!response_prog_full && n < N_FILL_MAX) begin
            r = $random(seed);
            send_packet(random_packet(r[7:0] | 8'h01));
            n++;
        end
        if (!response_prog_full) begin
            errors++;
            $display("ERROR [%s] response_prog_full never rose after %0d packets",
                     test_name, n);
        end
        repeat (20) next_cycle();
        pop_mode = POP_ON;
        drain_output();

        test_name = "final";
        check_value("config_request total cycles", 128'(1), 128'(req_cycles));
        end_simulation();
    end

endmodule : forward_data_generator_tb

//--- verilog.f
hdl/forward_pkg.sv
hdl/packet_fifo.sv
hdl/response_intake.sv
hdl/forward_control.sv
hdl/hop_forwarder.sv
hdl/forward_data_generator.sv
verif/forward_data_generator_tb.sv
